/* common/icache_pkg.sv */
// icache shared definitions
// geometry, vector types, controller states

package icache_pkg;

  // address split: tag [19:10], index [9:2], byte offset [1:0]
  localparam int ADDR_W   = 20;   // byte address
  localparam int INDEX_W  = 8;    // 256 sets
  localparam int TAG_W    = 10;
  localparam int WORD_W   = 32;   // one word per line
  localparam int NUM_WAYS = 4;

  // request address, word aligned
  typedef logic [ADDR_W-1:0]  addr_t;

  // set number
  typedef logic [INDEX_W-1:0] index_t;

  // stored per way and line
  typedef logic [TAG_W-1:0]   tag_t;

  // instruction word
  typedef logic [WORD_W-1:0]  word_t;

  // way select, 0..3
  typedef logic [1:0]         way_t;

  // lru rank, 0 = most recent, 3 = least recent
  typedef logic [1:0]         rank_t;

  // request fsm
  typedef enum logic [1:0] {
    ST_IDLE   = 2'd0,   // nothing in flight
    ST_LOOKUP = 2'd1,   // rams read, compare this cycle
    ST_REFILL = 2'd2    // miss, waiting for fetch
  } ctrl_state_t;

endpackage

/* design/sync_ram.sv */
// inferred ram, registered read

module sync_ram #(
  parameter int WIDTH   = 32,
  parameter int DEPTH_W = 8
) (
  input  logic               CLK,
  input  logic               we,
  input  logic [DEPTH_W-1:0] raddr,
  input  logic [DEPTH_W-1:0] waddr,
  input  logic [WIDTH-1:0]   wdata,
  output logic [WIDTH-1:0]   rdata
);

  logic [WIDTH-1:0] mem [2**DEPTH_W];   // no init, contents qualified elsewhere

  // write lands at the edge
  always_ff @(posedge CLK) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // read port, one cycle latency
  // same-address collision returns old word
  always_ff @(posedge CLK) begin
    rdata <= mem[raddr];
  end

endmodule

/* icache/icache_way.sv */
// one cache way
// data array, tag array, tag compare

module icache_way (
  input  logic               CLK,
  input  icache_pkg::index_t rd_index,     // read set, next compare
  input  icache_pkg::index_t hold_index,   // write set on refill
  input  icache_pkg::tag_t   hold_tag,     // compare and write tag
  input  logic               we,
  input  icache_pkg::word_t  write_data,   // refill word
  output logic               tag_match,
  output icache_pkg::word_t  way_rdata
);

  icache_pkg::tag_t stored_tag;   // tag ram output

  // tag array
  sync_ram #(
    .WIDTH   (icache_pkg::TAG_W),
    .DEPTH_W (icache_pkg::INDEX_W)
  ) u_tag_ram (
    .CLK   (CLK),
    .we    (we),
    .raddr (rd_index),
    .waddr (hold_index),
    .wdata (hold_tag),
    .rdata (stored_tag)
  );

  // data array, same addressing as tags
  sync_ram #(
    .WIDTH   (icache_pkg::WORD_W),
    .DEPTH_W (icache_pkg::INDEX_W)
  ) u_data_ram (
    .CLK   (CLK),
    .we    (we),
    .raddr (rd_index),
    .waddr (hold_index),
    .wdata (write_data),
    .rdata (way_rdata)
  );

  // raw compare
  // valid bit is applied in the controller
  always_comb begin
    tag_match = (stored_tag == hold_tag);
  end

endmodule

/* icache/icache_repl.sv */
// valid bits and lru ranks
// victim choice, rank update

module icache_repl (
  input  logic                            CLK,
  input  logic                            resetn,
  input  icache_pkg::index_t              hold_index,   // set under compare
  input  logic                            hit,
  input  icache_pkg::way_t                hit_way,
  input  logic                            fill,         // refill of victim
  output logic [icache_pkg::NUM_WAYS-1:0] valid_vec,
  output icache_pkg::way_t                victim
);

  localparam int NUM_SETS = 2 ** icache_pkg::INDEX_W;

  logic [icache_pkg::NUM_WAYS-1:0] valid_q [NUM_SETS];
  icache_pkg::rank_t rank_q [NUM_SETS][icache_pkg::NUM_WAYS];

  icache_pkg::rank_t set_rank [icache_pkg::NUM_WAYS];   // ranks of held set
  icache_pkg::way_t  used_way;                          // way touched this cycle
  icache_pkg::rank_t used_rank;
  logic [icache_pkg::NUM_WAYS-1:0] rank_seen;           // one bit per rank value

  // held set view, straight from the flops
  always_comb begin
    valid_vec = valid_q[hold_index];
    for (int w = 0; w < icache_pkg::NUM_WAYS; w++) begin
      set_rank[w] = rank_q[hold_index][w];
    end
  end

  // victim: lowest invalid way, else the lru way (rank 3)
  always_comb begin
    victim = '0;
    for (int w = icache_pkg::NUM_WAYS - 1; w >= 0; w--) begin
      if (set_rank[w] == icache_pkg::rank_t'(icache_pkg::NUM_WAYS - 1)) begin
        victim = icache_pkg::way_t'(w);
      end
    end
    // descending scan so the lowest invalid way wins
    for (int w = icache_pkg::NUM_WAYS - 1; w >= 0; w--) begin
      if (!valid_vec[w]) begin
        victim = icache_pkg::way_t'(w);
      end
    end
  end

  // a refill counts as a use of the victim
  always_comb begin
    used_way  = hit ? hit_way : victim;
    used_rank = set_rank[used_way];
  end

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      for (int s = 0; s < NUM_SETS; s++) begin
        valid_q[s] <= '0;
        for (int w = 0; w < icache_pkg::NUM_WAYS; w++) begin
          rank_q[s][w] <= icache_pkg::rank_t'(w);   // way w starts at rank w
        end
      end
    end else if (hit || fill) begin
      for (int w = 0; w < icache_pkg::NUM_WAYS; w++) begin
        if (icache_pkg::way_t'(w) == used_way) begin
          rank_q[hold_index][w] <= '0;   // now most recent
        end else if (set_rank[w] < used_rank) begin
          rank_q[hold_index][w] <= icache_pkg::rank_t'(set_rank[w] + 2'd1);   // ages by one
        end
      end
      if (fill) begin
        valid_q[hold_index][victim] <= 1'b1;
      end
    end
  end

  // every rank value present once in the held set
  always_comb begin
    rank_seen = '0;
    for (int w = 0; w < icache_pkg::NUM_WAYS; w++) begin
      rank_seen[set_rank[w]] = 1'b1;
    end
  end

  a_rank_perm: assert property (@(posedge CLK) disable iff (!resetn) &rank_seen)
    else $error("lru ranks of set %0d not distinct", hold_index);

endmodule

/* icache/icache_ctrl.sv */
// icache request controller
// fsm, address hold, hit merge, output mux

module icache_ctrl (
  input  logic                            CLK,
  input  logic                            resetn,
  input  logic                            read_en,
  input  icache_pkg::addr_t               read_addr,
  input  logic                            fetch,        // refill word present
  input  logic [icache_pkg::NUM_WAYS-1:0] tag_match,
  input  logic [icache_pkg::NUM_WAYS-1:0] valid_vec,
  input  icache_pkg::word_t               way_rdata [icache_pkg::NUM_WAYS],
  input  icache_pkg::way_t                victim,
  output icache_pkg::index_t              rd_index,
  output icache_pkg::index_t              hold_index,
  output icache_pkg::tag_t                hold_tag,
  output logic [icache_pkg::NUM_WAYS-1:0] way_we,
  output logic                            hit,
  output icache_pkg::way_t                hit_way,
  output logic                            fill,
  output logic                            cache_miss,
  output logic                            fetch_valid,
  output icache_pkg::word_t               rdata
);

  icache_pkg::ctrl_state_t state, next_state;
  logic [icache_pkg::NUM_WAYS-1:0] match_vec;   // valid ways with equal tag
  logic accept;                                 // request taken this edge

  assign match_vec = tag_match & valid_vec;

  // result of the held request, only meaningful in lookup
  assign hit         = (state == icache_pkg::ST_LOOKUP) && (|match_vec);
  assign fetch_valid = hit;
  assign cache_miss  = ((state == icache_pkg::ST_LOOKUP) && !hit)
                    || (state == icache_pkg::ST_REFILL);

  // fetch may already arrive in the first miss cycle
  assign fill = cache_miss && fetch;

  // idle, or a hit frees the compare stage for the next one
  assign accept = read_en && ((state == icache_pkg::ST_IDLE) || hit);

  // rams see the new index at the accept edge
  assign rd_index = accept ? read_addr[2 +: icache_pkg::INDEX_W] : hold_index;

  assign rdata = way_rdata[hit_way];

  // at most one bit set, plain encode
  always_comb begin
    hit_way = '0;
    for (int w = 0; w < icache_pkg::NUM_WAYS; w++) begin
      if (match_vec[w]) begin
        hit_way = icache_pkg::way_t'(w);
      end
    end
  end

  // refill goes to the victim only
  always_comb begin
    way_we = '0;
    if (fill) begin
      way_we[victim] = 1'b1;
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      icache_pkg::ST_IDLE: begin
        if (accept) next_state = icache_pkg::ST_LOOKUP;
      end
      icache_pkg::ST_LOOKUP: begin
        if (hit) begin
          next_state = accept ? icache_pkg::ST_LOOKUP : icache_pkg::ST_IDLE;
        end else if (fetch) begin
          next_state = icache_pkg::ST_IDLE;   // word written at this edge
        end else begin
          next_state = icache_pkg::ST_REFILL;
        end
      end
      icache_pkg::ST_REFILL: begin
        if (fetch) next_state = icache_pkg::ST_IDLE;
      end
      default: next_state = icache_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      state      <= icache_pkg::ST_IDLE;
      hold_index <= '0;
      hold_tag   <= '0;
    end else begin
      state <= next_state;
      if (accept) begin
        hold_index <= read_addr[2 +: icache_pkg::INDEX_W];
        hold_tag   <= read_addr[icache_pkg::ADDR_W-1 -: icache_pkg::TAG_W];
      end
    end
  end

  // a line is never filled into two ways of one set
  a_single_hit: assert property (@(posedge CLK) disable iff (!resetn)
    (state == icache_pkg::ST_LOOKUP) |-> $onehot0(match_vec))
    else $error("multiple valid ways match tag %h", hold_tag);

  // miss stays up until the refill word comes
  a_miss_hold: assert property (@(posedge CLK) disable iff (!resetn)
    cache_miss && !fetch |=> cache_miss)
    else $error("cache_miss dropped before fetch");

endmodule

/* icache/icache_top.sv */
// 4-way set-associative icache
// ways, replacement state, controller

module icache_top (
  input  logic              CLK,
  input  logic              resetn,
  input  logic              read_en,
  input  icache_pkg::addr_t read_addr,
  input  logic              fetch,
  input  icache_pkg::word_t write_data,   // refill word from requester
  output logic              cache_miss,
  output logic              fetch_valid,
  output icache_pkg::word_t rdata
);

  icache_pkg::index_t rd_index;
  icache_pkg::index_t hold_index;
  icache_pkg::tag_t   hold_tag;

  logic [icache_pkg::NUM_WAYS-1:0] way_we;      // one-hot refill strobe
  logic [icache_pkg::NUM_WAYS-1:0] tag_match;   // raw compare per way
  logic [icache_pkg::NUM_WAYS-1:0] valid_vec;
  icache_pkg::word_t way_rdata [icache_pkg::NUM_WAYS];

  logic             hit;
  icache_pkg::way_t hit_way;
  logic             fill;
  icache_pkg::way_t victim;

  // four identical ways, shared addressing
  for (genvar w = 0; w < icache_pkg::NUM_WAYS; w++) begin : g_way
    icache_way u_way (
      .CLK        (CLK),
      .rd_index   (rd_index),
      .hold_index (hold_index),
      .hold_tag   (hold_tag),
      .we         (way_we[w]),
      .write_data (write_data),
      .tag_match  (tag_match[w]),
      .way_rdata  (way_rdata[w])
    );
  end

  icache_repl u_repl (
    .CLK        (CLK),
    .resetn     (resetn),
    .hold_index (hold_index),
    .hit        (hit),
    .hit_way    (hit_way),
    .fill       (fill),
    .valid_vec  (valid_vec),
    .victim     (victim)
  );

  icache_ctrl u_ctrl (
    .CLK         (CLK),
    .resetn      (resetn),
    .read_en     (read_en),
    .read_addr   (read_addr),
    .fetch       (fetch),
    .tag_match   (tag_match),
    .valid_vec   (valid_vec),
    .way_rdata   (way_rdata),
    .victim      (victim),
    .rd_index    (rd_index),
    .hold_index  (hold_index),
    .hold_tag    (hold_tag),
    .way_we      (way_we),
    .hit         (hit),
    .hit_way     (hit_way),
    .fill        (fill),
    .cache_miss  (cache_miss),
    .fetch_valid (fetch_valid),
    .rdata       (rdata)
  );

endmodule

/* bench/icache_checker.sv */
// icache reference model and response checker

module icache_checker (
  input  logic              CLK,
  input  logic              resetn,
  input  logic              read_en,
  input  icache_pkg::addr_t read_addr,
  input  logic              fetch,
  input  icache_pkg::word_t write_data,
  input  logic              cache_miss,
  input  logic              fetch_valid,
  input  icache_pkg::word_t rdata,
  output int                check_count,
  output int                error_count
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_SETS = 256;
  localparam int NUM_WAYS = 4;

  icache_pkg::tag_t  m_tag   [NUM_SETS][NUM_WAYS];
  icache_pkg::word_t m_word  [NUM_SETS][NUM_WAYS];
  bit                m_valid [NUM_SETS][NUM_WAYS];
  int                m_rank  [NUM_SETS][NUM_WAYS];   // 0 = most recent

  bit pending;                   // request taken at the last edge
  bit in_miss;                   // waiting for the refill word
  icache_pkg::addr_t req_addr;
  int checks = 0;
  int errors = 0;

  assign check_count = checks;
  assign error_count = errors;

  // empty cache, way w at rank w
  function automatic void clear_model();
    for (int s = 0; s < NUM_SETS; s++) begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        m_valid[s][w] = 1'b0;
        m_rank[s][w]  = w;
      end
    end
    pending = 1'b0;
    in_miss = 1'b0;
  endfunction

  // -1 when the line is not held
  function automatic int find_way(icache_pkg::addr_t a);
    int way;
    way = -1;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (m_valid[a[9:2]][w] && m_tag[a[9:2]][w] == a[19:10]) way = w;
    end
    return way;
  endfunction

  // first empty way, else the oldest one
  function automatic int pick_victim(icache_pkg::index_t s);
    int v;
    v = -1;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (v < 0 && !m_valid[s][w]) v = w;
    end
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (v < 0 && m_rank[s][w] == NUM_WAYS - 1) v = w;
    end
    return v;
  endfunction

  // younger ways age by one, used way becomes newest
  function automatic void touch(icache_pkg::index_t s, int used);
    int r;
    r = m_rank[s][used];
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (m_rank[s][w] < r) m_rank[s][w] = m_rank[s][w] + 1;
    end
    m_rank[s][used] = 0;
  endfunction

  function automatic void compare(string name, logic [31:0] got, logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t ns %s expected %h got %h", $time, name, exp, got);
    end
  endfunction

  // inputs settle at the falling edge, so the rising edge sees stable values
  always @(posedge CLK) begin : watch
    icache_pkg::index_t s;
    int w;
    bit busy;
    if (!resetn) begin
      clear_model();
    end else begin
      s = req_addr[9:2];
      if (pending) begin   // result due this cycle
        w = find_way(req_addr);
        compare("fetch_valid", 32'(fetch_valid), 32'(w >= 0));
        compare("cache_miss", 32'(cache_miss), 32'(w < 0));
        if (w >= 0) begin
          compare("rdata", rdata, m_word[s][w]);
          touch(s, w);
        end else begin
          in_miss = 1'b1;
        end
        pending = 1'b0;
      end else begin
        compare("fetch_valid", 32'(fetch_valid), 32'(0));
        compare("cache_miss", 32'(cache_miss), 32'(in_miss));
      end
      busy = in_miss;   // no request taken while a miss is open
      if (in_miss && fetch) begin
        w = pick_victim(s);
        m_tag[s][w]   = req_addr[19:10];
        m_word[s][w]  = write_data;
        m_valid[s][w] = 1'b1;
        touch(s, w);   // refill counts as a use
        in_miss = 1'b0;
      end
      if (read_en && !busy) begin
        pending  = 1'b1;
        req_addr = read_addr;
      end
    end
  end

endmodule

/* bench/tb_icache.sv */
// icache testbench
// random reads over a small pool, miss service, watchdog

module tb_icache;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD      = 40;
  localparam int TOTAL_REQS      = 12 + 12 + 20 + 9 + 6;   // all tests together
  localparam int WATCHDOG_CYCLES = TOTAL_REQS * 10 + 100;
  localparam int LRU_TAGS [9]    = '{1, 2, 3, 0, 4, 0, 2, 3, 1};   // tag numbers, set 0

  logic CLK;
  logic resetn;
  logic read_en;
  icache_pkg::addr_t read_addr;
  logic fetch;
  icache_pkg::word_t write_data;
  logic cache_miss;
  logic fetch_valid;
  icache_pkg::word_t rdata;
  int check_count;
  int error_count;

  int seed = 23;
  icache_pkg::word_t  backing_mem [2**18];   // one word per word address
  icache_pkg::tag_t   pool_tag [6];
  icache_pkg::index_t pool_index [3];
  icache_pkg::addr_t  req_q [$];
  int drive_errors;                          // handshake faults seen by the driver
  int test_num;
  int last_checks;
  int last_errors;

  icache_top uut (
    .CLK         (CLK),
    .resetn      (resetn),
    .read_en     (read_en),
    .read_addr   (read_addr),
    .fetch       (fetch),
    .write_data  (write_data),
    .cache_miss  (cache_miss),
    .fetch_valid (fetch_valid),
    .rdata       (rdata)
  );

  icache_checker u_checker (
    .CLK         (CLK),
    .resetn      (resetn),
    .read_en     (read_en),
    .read_addr   (read_addr),
    .fetch       (fetch),
    .write_data  (write_data),
    .cache_miss  (cache_miss),
    .fetch_valid (fetch_valid),
    .rdata       (rdata),
    .check_count (check_count),
    .error_count (error_count)
  );

  initial begin
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge CLK);
    $display("timeout: run still busy after %0d cycles", WATCHDOG_CYCLES);
    $display("CHECKS FAILED");
    $finish;
  end

  function automatic icache_pkg::addr_t pool_addr(int t, int i);
    return {pool_tag[t], pool_index[i], 2'b00};
  endfunction

  task automatic apply_reset();
    @(negedge CLK);
    resetn = 1'b0;
    repeat (4) @(negedge CLK);   // four rising edges in reset
    resetn = 1'b1;
  endtask

  // answer an open miss after 0..5 cycles
  task automatic serve_miss(input icache_pkg::addr_t addr);
    int delay;
    delay = int'($unsigned($random(seed)) % 6);
    repeat (delay) @(negedge CLK);
    fetch      = 1'b1;
    write_data = backing_mem[addr[19:2]];
    @(negedge CLK);
    fetch = 1'b0;
  endtask

  // issue queued reads, back to back while they hit
  task automatic run_queue(output int misses);
    icache_pkg::addr_t cur;
    bit first;
    bit done;
    misses = 0;
    while (req_q.size() > 0) begin
      cur   = req_q.pop_front();
      first = 1'b1;
      done  = 1'b0;
      while (!done) begin
        read_en   = 1'b1;
        read_addr = cur;
        @(negedge CLK);
        read_en = 1'b0;
        if (fetch_valid) begin
          done = 1'b1;
        end else if (cache_miss) begin
          if (first) misses++;
          serve_miss(cur);   // then the same read again
        end else begin
          $display("no response one cycle after read of %h at %0t ns", cur, $time);
          drive_errors++;
          done = 1'b1;
        end
        first = 1'b0;
      end
    end
  endtask

  task automatic finish_test(input string name, input int misses, input int exp_misses);
    @(negedge CLK);   // let the checker see the last result
    if (misses != exp_misses) begin
      $display("[FAIL] %0t ns cache_miss first-try count expected %0d got %0d",
               $time, exp_misses, misses);
      drive_errors++;
    end
    test_num++;
    $display("test %0d %s: %0d checks, %0d errors", test_num, name,
             check_count - last_checks, error_count + drive_errors - last_errors);
    last_checks = check_count;
    last_errors = error_count + drive_errors;
  endtask

  initial begin
    int misses;
    logic [31:0] r;
    resetn       = 1'b0;
    read_en      = 1'b0;
    read_addr    = '0;
    fetch        = 1'b0;
    write_data   = '0;
    drive_errors = 0;
    test_num     = 0;
    last_checks  = 0;
    last_errors  = 0;
    for (int i = 0; i < 2**18; i++) begin
      backing_mem[i] = $random(seed);
    end
    r = $random(seed);   // xor with a small count keeps pool entries distinct
    for (int t = 0; t < 6; t++) pool_tag[t] = r[9:0] ^ icache_pkg::tag_t'(t);
    for (int i = 0; i < 3; i++) pool_index[i] = r[17:10] ^ icache_pkg::index_t'(i);
    apply_reset();

    for (int i = 0; i < 3; i++) begin   // four tags per set, all new
      for (int t = 0; t < 4; t++) req_q.push_back(pool_addr(t, i));
    end
    run_queue(misses);
    finish_test("cold misses", misses, 12);

    for (int i = 2; i >= 0; i--) begin   // same lines, reverse order
      for (int t = 3; t >= 0; t--) req_q.push_back(pool_addr(t, i));
    end
    run_queue(misses);
    finish_test("hit after refill", misses, 0);

    for (int k = 0; k < 20; k++) begin
      req_q.push_back(pool_addr($unsigned($random(seed)) % 4, $unsigned($random(seed)) % 3));
    end
    run_queue(misses);
    finish_test("back-to-back hits", misses, 0);

    // order set 0 as t0 newest, t1 oldest; t4 evicts t1, t1 then evicts t4
    for (int k = 0; k < 9; k++) req_q.push_back(pool_addr(LRU_TAGS[k], 0));
    run_queue(misses);
    finish_test("lru eviction", misses, 2);

    apply_reset();
    for (int t = 0; t < 6; t++) req_q.push_back(pool_addr(t, 0));
    run_queue(misses);
    finish_test("reset clears cache", misses, 6);

    $display("%0d tests, %0d checks, %0d errors", test_num, check_count,
             error_count + drive_errors);
    if (error_count + drive_errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

/* files.f */
common/icache_pkg.sv
design/sync_ram.sv
icache/icache_way.sv
icache/icache_repl.sv
icache/icache_ctrl.sv
icache/icache_top.sv
bench/icache_checker.sv
bench/tb_icache.sv

/* run_sim.sh */
#!/bin/sh
# build the icache testbench with verilator, run it, judge by the log

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f files.f \
  --top-module tb_icache -o sim_icache > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
  echo "build failed, see $BUILD_LOG"
  exit 1
fi

./obj_dir/sim_icache > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
  echo "simulator exited with status $status"
  exit 1
fi

if grep -q "^ALL CHECKS PASSED$" "$SIM_LOG"; then
  exit 0
fi
echo "pass line not found in $SIM_LOG"
exit 1
